// File: hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

	localparam int m_width = 32;
	localparam int lg_prf_entries = 6;

	typedef logic [lg_prf_entries-1:0] preg_t;

	localparam preg_t link_reg = 6'd31;	// jal and bgezal write $ra

	typedef enum logic [5:0] {
		II, NOP,
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		MOV, MOVI,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		J, JAL, JR, JALR,
		BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL,
		LB, LH, LW, LBU, LHU,
		SB, SH, SW
	} uop_op_t;

	typedef struct packed {
		logic [31:0] insn;
		logic [m_width-1:0] pc;
		logic insn_pred;
		logic [m_width-1:0] insn_pred_target;
	} fetch_bundle_t;

	typedef struct packed {
		uop_op_t op;
		preg_t srcA;
		preg_t srcB;
		preg_t dst;
		logic srcA_valid;
		logic srcB_valid;
		logic dst_valid;
		logic [15:0] imm;
		logic [15:0] jmp_imm;
		logic [m_width-1:0] pc;
		logic br_pred;
		logic is_br;
		logic has_delay_slot;
		logic has_nullifying_delay_slot;
		logic is_int;
		logic is_mem;
		logic is_store;
		logic serializing_op;	// kept for rename and never set by this decoder
	} uop_t;

	// architectural numbers zero padded up to a physical specifier
	function automatic preg_t reg_rs(input logic [31:0] insn);
		return {{(lg_prf_entries-5){1'b0}}, insn[25:21]};
	endfunction

	function automatic preg_t reg_rt(input logic [31:0] insn);
		return {{(lg_prf_entries-5){1'b0}}, insn[20:16]};
	endfunction

	function automatic preg_t reg_rd(input logic [31:0] insn);
		return {{(lg_prf_entries-5){1'b0}}, insn[15:11]};
	endfunction

	function automatic preg_t reg_shamt(input logic [31:0] insn);
		return {{(lg_prf_entries-5){1'b0}}, insn[10:6]};
	endfunction

endpackage

`default_nettype wire

// File: hdl/wb_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pipe_reg #(
	parameter type payload_t = logic
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic s_cyc,
	input wire logic s_stb,
	input wire payload_t s_dat,
	output logic s_ack,
	output logic m_cyc,
	output logic m_stb,
	output payload_t m_dat,
	input wire logic m_ack
);

	logic full;
	payload_t data;
	logic drain;

	assign drain = full & m_ack;	// entry leaves this cycle
	assign s_ack = s_cyc & s_stb & (!full | drain);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			full <= 1'b0;
		else if (s_ack)
			full <= 1'b1;	// load wins over a drain in the same cycle
		else if (drain)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (s_ack)
			data <= s_dat;
	end

	assign m_cyc = full;
	assign m_stb = full;
	assign m_dat = data;

endmodule

`default_nettype wire

// File: hdl/decode_special.sv
`timescale 1ns/1ps
`default_nettype none

module decode_special
	import decode_pkg::*;
(
	input wire logic [31:0] insn,
	input wire uop_t base,
	output logic hit,
	output uop_t uop
);

	preg_t rs;
	preg_t rt;
	preg_t rd;
	preg_t shamt;
	uop_op_t alu_op;

	assign rs = reg_rs(insn);
	assign rt = reg_rt(insn);
	assign rd = reg_rd(insn);
	assign shamt = reg_shamt(insn);
	assign hit = (insn[31:26] == 6'd0);	// unknown funct still hits as II

	// ops that write rd, II for everything else
	always_comb
	begin
		case (insn[5:0])
			6'd0: alu_op = SLL;	// zero word and ehb land here with rd 0
			6'd2: alu_op = SRL;
			6'd3: alu_op = SRA;
			6'd4: alu_op = SLLV;
			6'd6: alu_op = SRLV;
			6'd7: alu_op = SRAV;
			6'd33: alu_op = ADDU;
			6'd35: alu_op = SUBU;
			6'd36: alu_op = AND;
			6'd37: alu_op = (rs == '0) ? MOV : OR;
			6'd38: alu_op = XOR;
			6'd39: alu_op = NOR;
			6'd42: alu_op = SLT;
			6'd43: alu_op = SLTU;
			default: alu_op = II;
		endcase
	end

	always_comb
	begin
		uop = base;
		uop.imm = '0;
		uop.jmp_imm = '0;
		case (insn[5:0])
			6'd0, 6'd2, 6'd3:
			begin
				uop.srcA = rt;
				uop.srcA_valid = 1'b1;
				uop.srcB = shamt;	// shift amount with no register read
			end
			6'd35:
			begin
				// subu computes rs - rt so the operand order swaps
				uop.srcA = rs;
				uop.srcA_valid = 1'b1;
				uop.srcB = rt;
				uop.srcB_valid = 1'b1;
			end
			6'd37:
			begin
				uop.srcA = rt;
				uop.srcA_valid = 1'b1;
				uop.srcB = rs;
				uop.srcB_valid = (rs != '0);	// mov reads rt only
			end
			6'd8, 6'd9:
			begin
				uop.op = insn[0] ? JALR : JR;
				uop.srcA = rs;
				uop.srcA_valid = 1'b1;
				if (insn[0])
				begin
					uop.dst = rd;
					uop.dst_valid = (rd != '0);
				end
				// predicted target arrives split in the default uop
				uop.imm = base.imm;
				uop.jmp_imm = base.jmp_imm;
				uop.is_br = 1'b1;
				uop.is_int = 1'b1;
				uop.has_delay_slot = 1'b1;
			end
			default:
			begin
				if (alu_op != II)
				begin
					uop.srcA = rt;
					uop.srcA_valid = 1'b1;
					uop.srcB = rs;
					uop.srcB_valid = 1'b1;
				end
			end
		endcase

		if (alu_op != II)
		begin
			uop.op = (rd == '0) ? NOP : alu_op;	// write to $0 is a nop
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.is_int = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_branch.sv
`timescale 1ns/1ps
`default_nettype none

module decode_branch
	import decode_pkg::*;
(
	input wire fetch_bundle_t bundle,
	input wire uop_t base,
	output logic hit,
	output uop_t uop
);

	logic [31:0] insn;
	logic [5:0] opc;
	preg_t rs;
	preg_t rt;
	uop_op_t op;

	assign insn = bundle.insn;
	assign opc = insn[31:26];
	assign rs = reg_rs(insn);
	assign rt = reg_rt(insn);
	assign hit = (opc inside {[6'd1:6'd7], [6'd20:6'd23]});

	always_comb
	begin
		case (opc)
			6'd1:
				case (insn[20:16])	// regimm, keyed on rt
					5'd0: op = BLTZ;
					5'd1: op = BGEZ;
					5'd2: op = BLTZL;
					5'd3: op = BGEZL;
					5'd17: op = (rs == '0) ? BAL : BGEZAL;
					default: op = II;
				endcase
			6'd2: op = J;
			6'd3: op = JAL;
			6'd4: op = BEQ;
			6'd5: op = BNE;
			6'd6: op = BLEZ;
			6'd7: op = BGTZ;
			6'd20: op = BEQL;
			6'd21: op = BNEL;
			6'd22: op = BLEZL;
			6'd23: op = BGTZL;
			default: op = II;
		endcase
	end

	always_comb
	begin
		uop = base;
		uop.imm = '0;
		uop.jmp_imm = '0;
		if (op != II)
		begin
			uop.op = op;
			uop.is_br = 1'b1;
			uop.is_int = 1'b1;
			uop.has_delay_slot = 1'b1;
			if (opc == 6'd3)
			begin
				uop.imm = insn[15:0];
				uop.jmp_imm = {6'd0, insn[25:16]};
				uop.dst = link_reg;
				uop.dst_valid = 1'b1;
				uop.br_pred = 1'b1;	// always taken
			end
			else if (opc != 6'd2)	// j is folded at fetch
			begin
				uop.srcA = rs;
				uop.srcA_valid = 1'b1;
				uop.imm = insn[15:0];
				uop.br_pred = bundle.insn_pred;
				// likely forms flagged by rt bit 1 in regimm and opcode bit 4 elsewhere
				uop.has_nullifying_delay_slot = (opc == 6'd1) ? insn[17] : opc[4];
				if (opc[2] && !opc[1])
				begin
					uop.srcB = rt;	// beq/bne compare two registers
					uop.srcB_valid = 1'b1;
				end
				if (op == BGEZAL || op == BAL)
				begin
					uop.dst = link_reg;
					uop.dst_valid = 1'b1;
					uop.srcB = link_reg;
					uop.srcB_valid = (op == BGEZAL);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_itype.sv
`timescale 1ns/1ps
`default_nettype none

module decode_itype
	import decode_pkg::*;
(
	input wire logic [31:0] insn,
	input wire uop_t base,
	output logic hit,
	output uop_t uop
);

	logic [5:0] opc;
	preg_t rs;
	preg_t rt;
	uop_op_t op;

	assign opc = insn[31:26];
	assign rs = reg_rs(insn);
	assign rt = reg_rt(insn);
	assign hit = (op != II);

	always_comb
	begin
		case (opc)
			6'd9: op = (rs == '0) ? MOVI : ADDIU;
			6'd10: op = SLTI;
			6'd11: op = SLTIU;
			6'd12: op = ANDI;
			6'd13: op = ORI;
			6'd14: op = XORI;
			6'd15: op = LUI;
			6'd32: op = LB;
			6'd33: op = LH;
			6'd35: op = LW;
			6'd36: op = LBU;
			6'd37: op = LHU;
			6'd40: op = SB;
			6'd41: op = SH;
			6'd43: op = SW;
			6'd48: op = LW;	// ll taken as a plain load
			default: op = II;
		endcase
	end

	always_comb
	begin
		uop = base;
		uop.jmp_imm = '0;
		uop.imm = insn[15:0];
		uop.op = op;
		if (!opc[5])
		begin
			// immediate alu
			uop.srcA = rs;
			uop.srcA_valid = (op != MOVI) && (op != LUI);
			uop.dst = rt;
			uop.dst_valid = (rt != '0);
			uop.is_int = 1'b1;
			if (rt == '0)
				uop.op = NOP;
		end
		else
		begin
			uop.srcA = rs;	// base register
			uop.srcA_valid = 1'b1;
			uop.is_mem = 1'b1;
			if (opc[3])
			begin
				uop.srcB = rt;	// store data
				uop.srcB_valid = 1'b1;
				uop.is_store = 1'b1;
			end
			else
			begin
				uop.dst = rt;
				uop.dst_valid = (rt != '0);
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_mips32.sv
`timescale 1ns/1ps
`default_nettype none

module decode_mips32
	import decode_pkg::*;
(
	input wire fetch_bundle_t bundle,
	output uop_t uop
);

	uop_t dflt;
	uop_t special_uop;
	uop_t branch_uop;
	uop_t itype_uop;
	logic special_hit;
	logic branch_hit;
	logic itype_hit;

	// II with nothing valid; jr/jalr pick the predicted target out of imm/jmp_imm
	always_comb
	begin
		dflt = '0;
		dflt.op = II;
		dflt.pc = bundle.pc;
		dflt.imm = bundle.insn_pred_target[15:0];
		dflt.jmp_imm = bundle.insn_pred_target[m_width-1:16];
	end

	decode_special u_special (
		.insn(bundle.insn),
		.base(dflt),
		.hit(special_hit),
		.uop(special_uop)
	);

	decode_branch u_branch (
		.bundle(bundle),
		.base(dflt),
		.hit(branch_hit),
		.uop(branch_uop)
	);

	decode_itype u_itype (
		.insn(bundle.insn),
		.base(dflt),
		.hit(itype_hit),
		.uop(itype_uop)
	);

	// opcode ranges are disjoint, so at most one hit
	always_comb
	begin
		if (special_hit)
			uop = special_uop;
		else if (branch_hit)
			uop = branch_uop;
		else if (itype_hit)
			uop = itype_uop;
		else
		begin
			uop = dflt;
			uop.imm = '0;
			uop.jmp_imm = '0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
	import decode_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_cyc,
	input wire logic in_stb,
	input wire fetch_bundle_t in_dat,
	output logic in_ack,
	output logic out_cyc,
	output logic out_stb,
	output uop_t out_dat,
	input wire logic out_ack
);

	logic fb_cyc;
	logic fb_stb;
	logic fb_ack;	// uop register accepting is the bundle register's drain
	fetch_bundle_t fb_dat;
	uop_t dec_uop;

	wb_pipe_reg #(.payload_t(fetch_bundle_t)) u_bundle_reg (
		.clk(clk),
		.arst_n(arst_n),
		.s_cyc(in_cyc),
		.s_stb(in_stb),
		.s_dat(in_dat),
		.s_ack(in_ack),
		.m_cyc(fb_cyc),
		.m_stb(fb_stb),
		.m_dat(fb_dat),
		.m_ack(fb_ack)
	);

	decode_mips32 u_decode (
		.bundle(fb_dat),
		.uop(dec_uop)
	);

	wb_pipe_reg #(.payload_t(uop_t)) u_uop_reg (
		.clk(clk),
		.arst_n(arst_n),
		.s_cyc(fb_cyc),
		.s_stb(fb_stb),
		.s_dat(dec_uop),
		.s_ack(fb_ack),
		.m_cyc(out_cyc),
		.m_stb(out_stb),
		.m_dat(out_dat),
		.m_ack(out_ack)
	);

endmodule

`default_nettype wire

// File: tb/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
	import decode_pkg::*;
();

	localparam int trace_len = 36;
	localparam int words_per_line = 14;
	localparam int cycle_limit = 20 * trace_len + 50;

	logic clk;
	logic arst_n;
	logic in_cyc;
	logic in_stb;
	fetch_bundle_t in_dat;
	logic in_ack;
	logic out_cyc;
	logic out_stb;
	uop_t out_dat;
	logic out_ack;

	logic [31:0] trace_mem [0:trace_len*words_per_line-1];
	uop_t expect_q[$];	// one entry per accepted bundle
	integer seed = 32'hbbc6;
	int accepted;
	int received;
	int cycles;

	decode_stage uut (
		.clk(clk),
		.arst_n(arst_n),
		.in_cyc(in_cyc),
		.in_stb(in_stb),
		.in_dat(in_dat),
		.in_ack(in_ack),
		.out_cyc(out_cyc),
		.out_stb(out_stb),
		.out_dat(out_dat),
		.out_ack(out_ack)
	);

	always #4 clk = ~clk;

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		stop_failed($sformatf("CHECK FAILED at %0t ns: %s got %0h expected %0h",
			$time, name, got, want));
	endtask

	task automatic check_op(input uop_op_t got, input uop_op_t want);
		if (got !== want)
			stop_failed($sformatf("CHECK FAILED at %0t ns: op got %s expected %s",
				$time, got.name(), want.name()));
	endtask

	// everything except op
	task automatic check_uop(input uop_t got, input uop_t want);
		if (got.srcA !== want.srcA) report_mismatch("srcA", 32'(got.srcA), 32'(want.srcA));
		if (got.srcB !== want.srcB) report_mismatch("srcB", 32'(got.srcB), 32'(want.srcB));
		if (got.dst !== want.dst) report_mismatch("dst", 32'(got.dst), 32'(want.dst));
		if (got.srcA_valid !== want.srcA_valid)
			report_mismatch("srcA_valid", 32'(got.srcA_valid), 32'(want.srcA_valid));
		if (got.srcB_valid !== want.srcB_valid)
			report_mismatch("srcB_valid", 32'(got.srcB_valid), 32'(want.srcB_valid));
		if (got.dst_valid !== want.dst_valid)
			report_mismatch("dst_valid", 32'(got.dst_valid), 32'(want.dst_valid));
		if (got.imm !== want.imm) report_mismatch("imm", 32'(got.imm), 32'(want.imm));
		if (got.jmp_imm !== want.jmp_imm)
			report_mismatch("jmp_imm", 32'(got.jmp_imm), 32'(want.jmp_imm));
		if (got.pc !== want.pc) report_mismatch("pc", got.pc, want.pc);
		if (got.br_pred !== want.br_pred)
			report_mismatch("br_pred", 32'(got.br_pred), 32'(want.br_pred));
		if (got.is_br !== want.is_br) report_mismatch("is_br", 32'(got.is_br), 32'(want.is_br));
		if (got.has_delay_slot !== want.has_delay_slot)
			report_mismatch("has_delay_slot", 32'(got.has_delay_slot),
				32'(want.has_delay_slot));
		if (got.has_nullifying_delay_slot !== want.has_nullifying_delay_slot)
			report_mismatch("has_nullifying_delay_slot", 32'(got.has_nullifying_delay_slot),
				32'(want.has_nullifying_delay_slot));
		if (got.is_int !== want.is_int)
			report_mismatch("is_int", 32'(got.is_int), 32'(want.is_int));
		if (got.is_mem !== want.is_mem)
			report_mismatch("is_mem", 32'(got.is_mem), 32'(want.is_mem));
		if (got.is_store !== want.is_store)
			report_mismatch("is_store", 32'(got.is_store), 32'(want.is_store));
		if (got.serializing_op !== want.serializing_op)
			report_mismatch("serializing_op", 32'(got.serializing_op),
				32'(want.serializing_op));
	endtask

	function automatic fetch_bundle_t trace_bundle(input int idx);
		fetch_bundle_t b;
		int w;
		w = idx * words_per_line;
		b.insn = trace_mem[w];
		b.pc = trace_mem[w+1];
		b.insn_pred = trace_mem[w+2][0];
		b.insn_pred_target = trace_mem[w+3];
		return b;
	endfunction

	function automatic uop_t trace_uop(input int idx);
		uop_t u;
		int w;
		logic [31:0] flags;
		w = idx * words_per_line;
		flags = trace_mem[w+13];
		u = '0;	// serializing_op never set
		u.op = uop_op_t'(trace_mem[w+4][5:0]);
		u.srcA = trace_mem[w+5][5:0];
		u.srcA_valid = trace_mem[w+6][0];
		u.srcB = trace_mem[w+7][5:0];
		u.srcB_valid = trace_mem[w+8][0];
		u.dst = trace_mem[w+9][5:0];
		u.dst_valid = trace_mem[w+10][0];
		u.imm = trace_mem[w+11][15:0];
		u.jmp_imm = trace_mem[w+12][15:0];
		u.pc = trace_mem[w+1];	// pc rides along unchanged
		u.br_pred = flags[6];
		u.is_br = flags[5];
		u.has_delay_slot = flags[4];
		u.has_nullifying_delay_slot = flags[3];
		u.is_int = flags[2];
		u.is_mem = flags[1];
		u.is_store = flags[0];
		return u;
	endfunction

	// random consumer stalls
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_ack <= 1'b0;
		else
			out_ack <= (($random(seed) & 3) != 0);
	end

	// handshakes seen at mid cycle complete at the next rising edge
	always @(negedge clk)
	begin
		uop_t want;
		if (arst_n)
		begin
			if ((out_cyc || out_stb) && accepted == 0)
				stop_failed("out_cyc or out_stb went high before any bundle was accepted");
			if (out_cyc && out_stb && out_ack)
			begin
				if (expect_q.size() == 0)
					stop_failed("a uop arrived with no accepted bundle left to match it");
				want = expect_q.pop_front();
				check_op(out_dat.op, want.op);
				check_uop(out_dat, want);
				received++;
			end
			if (in_cyc && in_stb && in_ack)
			begin
				expect_q.push_back(trace_uop(accepted));
				accepted++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
			stop_failed($sformatf("timeout after %0d cycles, uops stopped arriving (%0d of %0d)",
				cycles, received, trace_len));
	end

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		in_cyc = 1'b0;
		in_stb = 1'b0;
		in_dat = '0;
		out_ack = 1'b0;
		accepted = 0;
		received = 0;
		cycles = 0;
		$readmemh("tb/decode_trace.txt", trace_mem);
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < trace_len; i++)
		begin
			while (($random(seed) & 3) == 0)
			begin
				in_stb <= 1'b0;	// fetch bubble
				@(posedge clk);
			end
			in_cyc <= 1'b1;
			in_stb <= 1'b1;
			in_dat <= trace_bundle(i);
			@(negedge clk);
			while (!in_ack)
				@(negedge clk);
			@(posedge clk);
		end
		in_cyc <= 1'b0;
		in_stb <= 1'b0;
		wait (received == trace_len);
		repeat (5) @(posedge clk);	// room for a stray extra uop to show up
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/decode_trace.txt
// insn pc pred target, then expected op srcA srcA_v srcB srcB_v dst dst_v imm jmp_imm flags
// op is the uop_op_t index; flags bits 6..0 = br_pred is_br delay nullify is_int is_mem is_store
00221821 00400000 1 12345678 08 02 1 01 1 03 1 0000 0000 04
00a62023 00400004 0 00000000 09 05 1 06 1 04 1 0000 0000 04
00083940 00400008 0 00000000 02 08 1 05 0 07 1 0000 0000 04
016a4807 0040000c 0 00000000 07 0a 1 0b 1 09 1 0000 0000 04
0022002a 00400010 0 00000000 01 02 1 01 1 00 0 0000 0000 04
00000000 00400014 0 00000000 01 00 1 00 0 00 0 0000 0000 04
000000c0 00400018 0 00000000 01 00 1 03 0 00 0 0000 0000 04
000d6025 0040001c 0 00000000 10 0d 1 00 0 0c 1 0000 0000 04
01cd6025 00400020 0 00000000 0b 0d 1 0e 1 0c 1 0000 0000 04
24021234 00400024 0 00000000 11 00 0 00 0 02 1 1234 0000 04
2483fff0 00400028 0 00000000 12 04 1 00 0 03 1 fff0 0000 04
30c500ff 0040002c 0 00000000 15 06 1 00 0 05 1 00ff 0000 04
3c08beef 00400030 0 00000000 18 00 0 00 0 08 1 beef 0000 04
29200003 00400034 0 00000000 01 09 1 00 0 00 0 0003 0000 04
10220010 00400038 1 00400078 1d 01 1 02 1 00 0 0010 0000 74
5464fffc 0040003c 0 00000000 22 03 1 04 1 00 0 fffc 0000 3c
18a00020 00400040 1 004000c4 1f 05 1 00 0 00 0 0020 0000 74
5cc00008 00400044 1 00400068 24 06 1 00 0 00 0 0008 0000 7c
04e20004 00400048 0 00000000 27 07 1 00 0 00 0 0004 0000 3c
05010100 0040004c 1 00400450 26 08 1 00 0 00 0 0100 0000 74
05310040 00400050 1 00400154 29 09 1 1f 1 1f 1 0040 0000 74
04110050 00400054 1 00400198 2a 00 1 1f 0 1f 1 0050 0000 74
08123456 00400058 1 048d1158 19 00 0 00 0 00 0 0000 0000 34
0fabcdef 0040005c 0 00000000 1a 00 0 00 0 1f 1 cdef 03ab 74
03e00008 00400060 1 8001a2b4 1b 1f 1 00 0 00 0 a2b4 8001 34
00c02809 00400064 1 00402000 1c 06 1 00 0 05 1 2000 0040 34
8fa20008 00400068 0 00000000 2d 1d 1 00 0 02 1 0008 0000 02
90800001 0040006c 0 00000000 2e 04 1 00 0 00 0 0001 0000 02
a507fffe 00400070 0 00000000 31 08 1 07 1 00 0 fffe 0000 03
afa30010 00400074 0 00000000 32 1d 1 03 1 00 0 0010 0000 03
c1490004 00400078 0 00000000 2d 0a 1 00 0 09 1 0004 0000 02
40026000 0040007c 0 cafef00d 00 00 0 00 0 00 0 0000 0000 00
00001010 00400080 1 cafef00d 00 00 0 00 0 00 0 0000 0000 00
70851802 00400084 0 cafef00d 00 00 0 00 0 00 0 0000 0000 00
00221805 00400088 0 cafef00d 00 00 0 00 0 00 0 0000 0000 00
041f0000 0040008c 1 cafef00d 00 00 0 00 0 00 0 0000 0000 00

// File: project.f
hdl/decode_pkg.sv
hdl/wb_pipe_reg.sv
hdl/decode_special.sv
hdl/decode_branch.sv
hdl/decode_itype.sv
hdl/decode_mips32.sv
hdl/decode_stage.sv
tb/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_decode_stage -f project.f --Mdir obj_dir -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" <<< "$sim_output"; then
	exit 0
fi
exit 1
